// ==== test/csr_vectors.txt ====
# op addr data cause pc expected, all hex, one cycle each
# W write, R read, T trap (addr not 000 adds a write), M mret, S sret, P mode, E enables, D time, X timer flags
W 305 00001000 00000000 00000000 00000000
R 305 00000000 00000000 00000000 00001000
W 340 deadbeef 00000000 00000000 00000000
R 340 00000000 00000000 00000000 deadbeef
W 302 12345a5a 00000000 00000000 00000000
R 302 00000000 00000000 00000000 00005a5a
W 303 00000fff 00000000 00000000 00000000
R 303 00000000 00000000 00000000 00000fff
W 100 00000122 00000000 00000000 00000000
R 300 00000000 00000000 00000000 00001922
R 100 00000000 00000000 00000000 00000122
R 7c0 00000000 00000000 00000000 00000000
R 301 00000000 00000000 00000000 40141101
R f14 00000000 00000000 00000000 00000000
W 300 00001808 00000000 00000000 00000000
R 300 00000000 00000000 00000000 00001808
T 000 00000000 00000000 00002007 00001000
P 000 00000000 00000000 00000000 00000003
R 341 00000000 00000000 00000000 00002004
R 342 00000000 00000000 00000000 00000000
R 343 00000000 00000000 00000000 00002006
R 300 00000000 00000000 00000000 00001880
W 300 00000880 00000000 00000000 00000000
R 300 00000000 00000000 00000000 00000880
M 000 00000000 00000000 00000000 00002004
P 000 00000000 00000000 00000000 00000001
R 300 00000000 00000000 00000000 00000088
W 302 00000008 00000000 00000000 00000000
W 105 00003000 00000000 00000000 00000000
W 100 00000002 00000000 00000000 00000000
T 000 00000000 00000003 00004010 00003000
P 000 00000000 00000000 00000000 00000001
R 141 00000000 00000000 00000000 00004010
R 142 00000000 00000000 00000000 00000003
R 143 00000000 00000000 00000000 00000000
R 100 00000000 00000000 00000000 00000120
T 000 00000000 00000002 00004020 00001000
P 000 00000000 00000000 00000000 00000003
R 300 00000000 00000000 00000000 000009a0
R 341 00000000 00000000 00000000 00004020
R 342 00000000 00000000 00000000 00000002
S 000 00000000 00000000 00000000 00004010
P 000 00000000 00000000 00000000 00000001
R 100 00000000 00000000 00000000 00000022
S 000 00000000 00000000 00000000 00004010
P 000 00000000 00000000 00000000 00000000
T 000 00000000 00000002 00005000 00001000
P 000 00000000 00000000 00000000 00000003
R 300 00000000 00000000 00000000 00000022
R 341 00000000 00000000 00000000 00005000
T 340 11111111 00000002 00006000 00001000
R 340 00000000 00000000 00000000 deadbeef
R 341 00000000 00000000 00000000 00006000
W 304 00000aa0 00000000 00000000 00000000
R 304 00000000 00000000 00000000 00000aa0
R 104 00000000 00000000 00000000 00000220
E 000 00000000 00000000 00000000 00000003
W 300 00000008 00000000 00000000 00000000
E 000 00000000 00000000 00000000 0000000c
W 104 00000200 00000000 00000000 00000000
E 000 00000000 00000000 00000000 0000000c
W 100 00000002 00000000 00000000 00000000
E 000 00000000 00000000 00000000 0000000e
W bbf 00000020 00000000 00000000 00000000
W 5c0 0000ffff 00000000 00000000 00000000
R bbf 00000000 00000000 00000000 00000020
R 5c0 00000000 00000000 00000000 0000ffff
D c01 00000000 00000000 00000000 00000000
D c01 00000000 00000000 00000000 00000000
X 000 00000000 00000000 00000000 00000000
R c81 00000000 00000000 00000000 00000000
W 5c0 00000010 00000000 00000000 00000000
W bbf ffffffff 00000000 00000000 00000000
D c01 00000000 00000000 00000000 00000000
X 000 00000000 00000000 00000000 00000000

// ==== sim.f ====
+incdir+src
src/csr_pkg.sv
src/priv_mode_fsm.sv
src/mtime_counter.sv
src/trap_csrs.sv
src/csr_read_mux.sv
src/csr_file_top.sv
test/tb_clock_gen.sv
test/csr_file_tb.sv

// ==== Bender.yml ====
package:
  name: csr_file

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/csr_pkg.sv
      - src/priv_mode_fsm.sv
      - src/mtime_counter.sv
      - src/trap_csrs.sv
      - src/csr_read_mux.sv
      - src/csr_file_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_clock_gen.sv
      - test/csr_file_tb.sv

// ==== test/csr_file_tb.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_file_tb;

	import csr_pkg::*;

	localparam int MAX_VECTORS = 256;

	logic           clk;
	logic           nrst;
	csr_wr_t        csr_wr;
	logic [11:0]    rd_addr;
	trap_req_t      trap;
	logic           mret;
	logic           sret;
	irq_in_t        irq;
	logic [31:0]    rd_data;
	logic [31:0]    epc;
	logic [1:0]     current_mode;
	logic           m_timer, s_timer;
	logic           m_eie, m_tie, s_eie, s_tie;

	// vector table
	logic [7:0]     v_op [0:MAX_VECTORS-1];
	logic [11:0]    v_addr [0:MAX_VECTORS-1];
	logic [31:0]    v_data [0:MAX_VECTORS-1];
	logic [31:0]    v_cause [0:MAX_VECTORS-1];
	logic [31:0]    v_pc [0:MAX_VECTORS-1];
	logic [31:0]    v_exp [0:MAX_VECTORS-1];
	int             n_vec;

	int unsigned    cycle_count;
	int unsigned    cycle_limit;
	logic [63:0]    run_cycles; // own count of cycles since reset
	logic [63:0]    last_time;
	logic [31:0]    mtimecmp_model;
	logic [31:0]    stimecmp_model;

	tb_clock_gen u_clk
	(
		.clk(clk),
		.nrst(nrst)
	);

	csr_file_top DUT
	(
		.clk(clk), .nrst(nrst), .csr_wr(csr_wr), .rd_addr(rd_addr), .trap(trap),
		.mret(mret), .sret(sret), .irq(irq), .rd_data(rd_data), .epc(epc),
		.current_mode(current_mode), .m_timer(m_timer), .s_timer(s_timer),
		.m_eie(m_eie), .m_tie(m_tie), .s_eie(s_eie), .s_tie(s_tie)
	);

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("Mismatch at %0t: %s read %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic idle_inputs();
		csr_wr = '0;
		rd_addr = '0;
		trap = '0;
		mret = 1'b0;
		sret = 1'b0;
		irq = '0;
	endtask

	task automatic load_vectors();
		int             fd;
		int             cnt;
		logic [7:0]     op;
		logic [11:0]    addr;
		logic [31:0]    data, cause, pc, exp;
		logic [8*160-1:0] line;
		fd = $fopen("test/csr_vectors.txt", "r");
		if (fd == 0)
			stop_with_failure("Could not open the vector file test/csr_vectors.txt");
		n_vec = 0;
		line = '0;
		while ($fgets(line, fd) != 0)
		begin
			op = " ";
			cnt = $sscanf(line, " %c %h %h %h %h %h", op, addr, data, cause, pc, exp);
			if (cnt > 0 && op != "#") // comments and blank lines skipped
			begin
				if (cnt != 6)
					stop_with_failure("A line of the vector file has the wrong number of fields");
				if (n_vec == MAX_VECTORS)
					stop_with_failure("The vector file holds more lines than the table");
				v_op[n_vec] = op;
				v_addr[n_vec] = addr;
				v_data[n_vec] = data;
				v_cause[n_vec] = cause;
				v_pc[n_vec] = pc;
				v_exp[n_vec] = exp;
				n_vec++;
			end
			line = '0;
		end
		$fclose(fd);
	endtask

	// one operation per cycle, checks 1 ns before the rising edge
	task automatic run_vector(input int i);
		@(negedge clk);
		idle_inputs();
		case (v_op[i])
			"W":
			begin
				csr_wr.en = 1'b1;
				csr_wr.addr = v_addr[i];
				csr_wr.data = v_data[i];
				if (v_addr[i] == `CSR_MTIMECMP)
					mtimecmp_model = v_data[i];
				if (v_addr[i] == `CSR_STIMECMP)
					stimecmp_model = v_data[i];
			end
			"R", "D":   rd_addr = v_addr[i];
			"T":
			begin
				trap.pending = 1'b1;
				trap.cause.raw = v_cause[i];
				trap.pc = v_pc[i];
				if (v_addr[i] != 12'h000) // write that must be dropped
				begin
					csr_wr.en = 1'b1;
					csr_wr.addr = v_addr[i];
					csr_wr.data = v_data[i];
				end
			end
			"M":        mret = 1'b1;
			"S":        sret = 1'b1;
			"P", "E", "X":
			begin
			end
			default:    stop_with_failure($sformatf("Unknown operation on vector line %0d", i));
		endcase
		#1;
		case (v_op[i])
			"R":        check_value(rd_data, v_exp[i], $sformatf("csr %h", v_addr[i]));
			"T":        check_value(epc, v_exp[i], "trap vector");
			"M":        check_value(epc, v_exp[i], "mret target");
			"S":        check_value(epc, v_exp[i], "sret target");
			"P":        check_value(current_mode, v_exp[i][1:0], "privilege mode");
			"E":        check_value({m_eie, m_tie, s_eie, s_tie}, v_exp[i][3:0], "enables");
			"D":
			begin
				check_value(rd_data, run_cycles[31:0], "time low word");
				last_time = run_cycles;
			end
			"X":
			begin
				check_value({m_timer, s_timer},
					{last_time >= {32'b0, mtimecmp_model}, last_time >= {32'b0, stimecmp_model}},
					"timer flags");
			end
			default:
			begin
			end
		endcase
	endtask

	always @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			run_cycles <= '0;
		else
			run_cycles <= run_cycles + 64'd1;
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
			stop_with_failure("The run went past its cycle limit without finishing");
	end

	initial
	begin
		idle_inputs();
		cycle_count = 0;
		cycle_limit = 200;
		last_time = '0;
		mtimecmp_model = '0;
		stimecmp_model = '0;
		load_vectors();
		cycle_limit = 40 * n_vec + 200;
		@(posedge nrst);
		for (int i = 0; i < n_vec; i++)
			run_vector(i);
		@(negedge clk);
		idle_inputs();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk; // 4 ns period
	end

	initial
	begin
		nrst = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk); // release away from the active edge
		nrst = 1'b1;
	end

endmodule

// ==== src/csr_file_top.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_file_top
(
	input  logic                    clk,
	input  logic                    nrst,
	input  csr_pkg::csr_wr_t        csr_wr,
	input  logic [11:0]             rd_addr,
	input  csr_pkg::trap_req_t      trap,
	input  logic                    mret,
	input  logic                    sret,
	input  csr_pkg::irq_in_t        irq,
	output logic [`XLEN-1:0]        rd_data,
	output logic [`XLEN-1:0]        epc,
	output logic [1:0]              current_mode,
	output logic                    m_timer,
	output logic                    s_timer,
	output logic                    m_eie,
	output logic                    m_tie,
	output logic                    s_eie,
	output logic                    s_tie
);

	import csr_pkg::*;

	trap_act_t          act;
	csr_wr_t            wr_ok; // write after trap/return gating
	priv_state_t        priv_state;
	csr_state_t         state;
	logic [63:0]        time_val;
	logic [`XLEN-1:0]   mtimecmp, stimecmp;

	priv_mode_fsm u_fsm
	(
		.clk(clk), .nrst(nrst), .trap(trap), .mret(mret), .sret(sret), .csr_wr(csr_wr),
		.priv_state(priv_state), .act(act), .wr_ok(wr_ok), .current_mode(current_mode)
	);

	mtime_counter u_timer
	(
		.clk(clk), .nrst(nrst), .wr_ok(wr_ok), .time_val(time_val), .mtimecmp(mtimecmp),
		.stimecmp(stimecmp), .m_timer(m_timer), .s_timer(s_timer)
	);

	trap_csrs u_csrs
	(
		.clk(clk), .nrst(nrst), .act(act), .wr_ok(wr_ok), .trap(trap),
		.current_mode(current_mode), .priv_state(priv_state), .state(state)
	);

	csr_read_mux u_rd
	(
		.rd_addr(rd_addr), .state(state), .irq(irq), .m_timer(m_timer), .s_timer(s_timer),
		.time_val(time_val), .mtimecmp(mtimecmp), .stimecmp(stimecmp), .act(act),
		.rd_data(rd_data), .epc(epc), .m_eie(m_eie), .m_tie(m_tie), .s_eie(s_eie),
		.s_tie(s_tie)
	);

endmodule

// ==== src/csr_read_mux.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_read_mux
(
	input  logic [11:0]             rd_addr,
	input  csr_pkg::csr_state_t     state,
	input  csr_pkg::irq_in_t        irq,
	input  logic                    m_timer,
	input  logic                    s_timer,
	input  logic [63:0]             time_val,
	input  logic [`XLEN-1:0]        mtimecmp,
	input  logic [`XLEN-1:0]        stimecmp,
	input  csr_pkg::trap_act_t      act,
	output logic [`XLEN-1:0]        rd_data,
	output logic [`XLEN-1:0]        epc,
	output logic                    m_eie,
	output logic                    m_tie,
	output logic                    s_eie,
	output logic                    s_tie
);

	logic [`XLEN-1:0] mstatus, sstatus, mip, sip, mie, sie;

	assign mstatus = {19'b0, state.mpp, 2'b0, state.spp, state.mpie, 1'b0, state.spie,
		1'b0, state.mie, 1'b0, state.sie, 1'b0};
	assign sstatus = {23'b0, state.spp, 2'b0, state.spie, 3'b0, state.sie, 1'b0};

	// pending bits come straight from the lines and timer flags
	assign mip = {20'b0, irq.m_ext, 1'b0, irq.s_ext, 1'b0, m_timer, 1'b0, s_timer, 5'b0};
	assign sip = {22'b0, irq.s_ext, 3'b0, s_timer, 5'b0};
	assign mie = {20'b0, state.meie, 1'b0, state.seie, 1'b0, state.mtie, 1'b0, state.stie, 5'b0};
	assign sie = {22'b0, state.seie, 3'b0, state.stie, 5'b0};

	always_comb
	begin
		case (rd_addr)
			`CSR_MISA:                  rd_data = `MISA_VALUE;
			`CSR_MVENDORID, `CSR_MARCHID,
			`CSR_MIMPID, `CSR_MHARTID:  rd_data = '0;
			`CSR_MSTATUS:               rd_data = mstatus;
			`CSR_MIP:                   rd_data = mip;
			`CSR_MIE:                   rd_data = mie;
			`CSR_MTVEC:                 rd_data = {state.mtvec, 2'b0};
			`CSR_MEPC:                  rd_data = {state.mepc, 2'b0};
			`CSR_MCAUSE:                rd_data = state.mcause.raw;
			`CSR_MTVAL:                 rd_data = state.mtval;
			`CSR_MSCRATCH:              rd_data = state.mscratch;
			`CSR_MEDELEG:               rd_data = {16'b0, state.medeleg};
			`CSR_MIDELEG:               rd_data = {20'b0, state.mideleg};
			`CSR_MTIMECMP:              rd_data = mtimecmp;
			`CSR_SSTATUS:               rd_data = sstatus;
			`CSR_SIP:                   rd_data = sip;
			`CSR_SIE:                   rd_data = sie;
			`CSR_STVEC:                 rd_data = {state.stvec, 2'b0};
			`CSR_SEPC:                  rd_data = {state.sepc, 2'b0};
			`CSR_SCAUSE:                rd_data = state.scause.raw;
			`CSR_STVAL:                 rd_data = state.stval;
			`CSR_SSCRATCH:              rd_data = state.sscratch;
			`CSR_STIMECMP:              rd_data = stimecmp;
			`CSR_TIME, `CSR_CYCLE:      rd_data = time_val[31:0];
			`CSR_TIMEH, `CSR_CYCLEH:    rd_data = time_val[63:32];
			default:                    rd_data = '0;
		endcase
	end

	// next fetch address for the front end
	always_comb
	begin
		if (act.ret_m)
			epc = {state.mepc, 2'b0};
		else if (act.ret_s)
			epc = {state.sepc, 2'b0};
		else if (act.enter_s)
			epc = {state.stvec, 2'b0};
		else
			epc = {state.mtvec, 2'b0};
	end

	assign m_eie = state.meie & state.mie;
	assign m_tie = state.mtie & state.mie;
	assign s_eie = state.seie & state.sie;
	assign s_tie = state.stie & state.sie;

endmodule

// ==== src/trap_csrs.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module trap_csrs
(
	input  logic                    clk,
	input  logic                    nrst,
	input  csr_pkg::trap_act_t      act,
	input  csr_pkg::csr_wr_t        wr_ok,
	input  csr_pkg::trap_req_t      trap,
	input  logic [1:0]              current_mode,
	output csr_pkg::priv_state_t    priv_state,
	output csr_pkg::csr_state_t     state
);

	import csr_pkg::*;

	csr_state_t         st;
	logic [`XLEN-1:0]   tval; // shared by both trap levels

	assign tval = (!trap.cause.f.intr && trap.cause.f.code == `CAUSE_I_ADDR_MISALIGNED) ?
		{trap.pc[`XLEN-1:1], 1'b0} : '0;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			st <= '0;
			st.mpp <= `MODE_M;
		end
		else if (wr_ok.en)
		begin
			case (wr_ok.addr)
				`CSR_MSTATUS:
				begin
					st.sie  <= wr_ok.data[1];
					st.mie  <= wr_ok.data[3];
					st.spie <= wr_ok.data[5];
					st.mpie <= wr_ok.data[7];
					st.spp  <= wr_ok.data[8];
					// reserved 2'b10 maps to U
					st.mpp  <= (wr_ok.data[12:11] == 2'b10) ? `MODE_U : wr_ok.data[12:11];
				end
				`CSR_SSTATUS:
				begin
					st.sie  <= wr_ok.data[1];
					st.spie <= wr_ok.data[5];
					st.spp  <= wr_ok.data[8];
				end
				`CSR_MIE:
				begin
					st.stie <= wr_ok.data[5];
					st.mtie <= wr_ok.data[7];
					st.seie <= wr_ok.data[9];
					st.meie <= wr_ok.data[11];
				end
				`CSR_SIE:
				begin
					st.stie <= wr_ok.data[5];
					st.seie <= wr_ok.data[9];
				end
				`CSR_MTVEC:     st.mtvec <= wr_ok.data[`XLEN-1:2];
				`CSR_STVEC:     st.stvec <= wr_ok.data[`XLEN-1:2];
				`CSR_MSCRATCH:  st.mscratch <= wr_ok.data;
				`CSR_SSCRATCH:  st.sscratch <= wr_ok.data;
				`CSR_MEPC:      st.mepc <= wr_ok.data[`XLEN-1:2];
				`CSR_SEPC:      st.sepc <= wr_ok.data[`XLEN-1:2];
				`CSR_MCAUSE:    st.mcause.raw <= wr_ok.data;
				`CSR_SCAUSE:    st.scause.raw <= wr_ok.data;
				`CSR_MTVAL:     st.mtval <= wr_ok.data;
				`CSR_STVAL:     st.stval <= wr_ok.data;
				`CSR_MEDELEG:   st.medeleg <= wr_ok.data[15:0];
				`CSR_MIDELEG:   st.mideleg <= wr_ok.data[11:0];
				default:        st <= st; // timer and read-only addresses
			endcase
		end
		else if (act.enter_m)
		begin
			st.mepc   <= trap.pc[`XLEN-1:2];
			st.mcause <= trap.cause;
			st.mtval  <= tval;
			st.mpie   <= st.mie;
			st.mie    <= 1'b0;
			st.mpp    <= current_mode;
		end
		else if (act.enter_s)
		begin
			st.sepc   <= trap.pc[`XLEN-1:2];
			st.scause <= trap.cause;
			st.stval  <= tval;
			st.spie   <= st.sie;
			st.sie    <= 1'b0;
			st.spp    <= current_mode[0]; // only S or U can land here
		end
		else if (act.ret_m)
		begin
			st.mie  <= st.mpie;
			st.mpie <= 1'b1;
			st.mpp  <= `MODE_U;
		end
		else if (act.ret_s)
		begin
			st.sie  <= st.spie;
			st.spie <= 1'b1;
			st.spp  <= 1'b0;
		end
	end

	assign priv_state.mpp     = st.mpp;
	assign priv_state.spp     = st.spp;
	assign priv_state.medeleg = st.medeleg;
	assign priv_state.mideleg = st.mideleg;
	assign state = st;

endmodule

// ==== src/mtime_counter.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module mtime_counter
(
	input  logic                clk,
	input  logic                nrst,
	input  csr_pkg::csr_wr_t    wr_ok,
	output logic [63:0]         time_val,
	output logic [`XLEN-1:0]    mtimecmp,
	output logic [`XLEN-1:0]    stimecmp,
	output logic                m_timer,
	output logic                s_timer
);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			time_val <= '0;
		else
			time_val <= time_val + 64'd1; // also serves cycle reads
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			mtimecmp <= '0;
			stimecmp <= '0;
		end
		else if (wr_ok.en)
		begin
			if (wr_ok.addr == `CSR_MTIMECMP)
				mtimecmp <= wr_ok.data;
			if (wr_ok.addr == `CSR_STIMECMP)
				stimecmp <= wr_ok.data;
		end
	end

	// flags lag the counter by one cycle
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			m_timer <= 1'b0;
			s_timer <= 1'b0;
		end
		else
		begin
			m_timer <= (time_val >= {32'b0, mtimecmp});
			s_timer <= (time_val >= {32'b0, stimecmp});
		end
	end

endmodule

// ==== src/priv_mode_fsm.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module priv_mode_fsm
(
	input  logic                    clk,
	input  logic                    nrst,
	input  csr_pkg::trap_req_t      trap,
	input  logic                    mret,
	input  logic                    sret,
	input  csr_pkg::csr_wr_t        csr_wr,
	input  csr_pkg::priv_state_t    priv_state,
	output csr_pkg::trap_act_t      act,
	output csr_pkg::csr_wr_t        wr_ok,
	output logic [1:0]              current_mode
);

	logic [1:0]     next_mode;
	logic [15:0]    ideleg_ext;
	logic           code_small; // code fits the delegation masks
	logic           deleg;

	assign ideleg_ext = {4'b0, priv_state.mideleg};
	assign code_small = (trap.cause.f.code[`XLEN-2:4] == '0);

	always_comb
	begin
		if (trap.cause.f.intr)
			deleg = code_small && ideleg_ext[trap.cause.f.code[3:0]];
		else
			deleg = code_small && priv_state.medeleg[trap.cause.f.code[3:0]];
	end

	// returns win over a pending trap
	always_comb
	begin
		act = '0;
		next_mode = current_mode;
		if (mret)
		begin
			act.ret_m = 1'b1;
			next_mode = priv_state.mpp;
		end
		else if (sret)
		begin
			act.ret_s = 1'b1;
			next_mode = priv_state.spp ? `MODE_S : `MODE_U;
		end
		else if (trap.pending)
		begin
			if (current_mode != `MODE_M && deleg) // M traps never leave M
			begin
				act.enter_s = 1'b1;
				next_mode = `MODE_S;
			end
			else
			begin
				act.enter_m = 1'b1;
				next_mode = `MODE_M;
			end
		end
	end

	// a software write loses to any trap or return
	always_comb
	begin
		wr_ok = csr_wr;
		if (act != '0)
			wr_ok.en = 1'b0;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			current_mode <= `MODE_M;
		else
			current_mode <= next_mode;
	end

endmodule

// ==== src/csr_pkg.sv ====
`include "csr_consts.svh"

package csr_pkg;

	typedef struct packed
	{
		logic               intr; // 1 for interrupts
		logic [`XLEN-2:0]   code;
	} cause_fields_t;

	// same word seen raw or split into flag and code
	typedef union packed
	{
		logic [`XLEN-1:0]   raw;
		cause_fields_t      f;
	} cause_u;

	typedef struct packed
	{
		logic               en;
		logic [11:0]        addr;
		logic [`XLEN-1:0]   data;
	} csr_wr_t;

	typedef struct packed
	{
		logic               pending;
		cause_u             cause;
		logic [`XLEN-1:0]   pc;
	} trap_req_t;

	// one-hot, all zero when idle
	typedef struct packed
	{
		logic enter_m;
		logic enter_s;
		logic ret_m;
		logic ret_s;
	} trap_act_t;

	typedef struct packed
	{
		logic [1:0]     mpp;
		logic           spp;
		logic [15:0]    medeleg;
		logic [11:0]    mideleg;
	} priv_state_t;

	typedef struct packed
	{
		logic               sie;
		logic               mie;
		logic               spie;
		logic               mpie;
		logic               spp;
		logic [1:0]         mpp;
		logic               meie;
		logic               seie;
		logic               mtie;
		logic               stie;
		logic [`XLEN-1:2]   mtvec; // direct mode, base only
		logic [`XLEN-1:2]   stvec;
		logic [`XLEN-1:0]   mscratch;
		logic [`XLEN-1:0]   sscratch;
		logic [`XLEN-1:2]   mepc;
		logic [`XLEN-1:2]   sepc;
		cause_u             mcause;
		cause_u             scause;
		logic [`XLEN-1:0]   mtval;
		logic [`XLEN-1:0]   stval;
		logic [15:0]        medeleg;
		logic [11:0]        mideleg;
	} csr_state_t;

	typedef struct packed
	{
		logic m_ext;
		logic s_ext;
	} irq_in_t;

endpackage

// ==== src/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define XLEN 32

// machine mode
`define CSR_MVENDORID   12'hf11
`define CSR_MARCHID     12'hf12
`define CSR_MIMPID      12'hf13
`define CSR_MHARTID     12'hf14
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MEDELEG     12'h302
`define CSR_MIDELEG     12'h303
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344
`define CSR_MTIMECMP    12'hbbf // low word only

// supervisor mode
`define CSR_SSTATUS     12'h100
`define CSR_SIE         12'h104
`define CSR_STVEC       12'h105
`define CSR_SSCRATCH    12'h140
`define CSR_SEPC        12'h141
`define CSR_SCAUSE      12'h142
`define CSR_STVAL       12'h143
`define CSR_SIP         12'h144
`define CSR_STIMECMP    12'h5c0

// counters, shared time base
`define CSR_CYCLE       12'hc00
`define CSR_TIME        12'hc01
`define CSR_CYCLEH      12'hc80
`define CSR_TIMEH       12'hc81

// privilege encodings
`define MODE_U 2'b00
`define MODE_S 2'b01
`define MODE_M 2'b11

`define CAUSE_I_ADDR_MISALIGNED 31'h0

// MXL=1, extensions A I M S U
`define MISA_VALUE 32'h4014_1101

`endif
